//--- files.f
common/msm_fetch_pkg.sv
hw/stream_fifo.sv
hw/kernel_ctrl.sv
hw/fetch/burst_reader.sv
hw/fetch/tuple_joiner.sv
hw/msm_fetch_top.sv
bench/msm_fetch_sva.sv
bench/tb_msm_fetch.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the MSM fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_msm_fetch -f files.f -o sim_msm_fetch \
  && ./obj_dir/sim_msm_fetch +verilator+error+limit+100 \
     | tee /dev/stderr | grep -q "Everything OK" \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- bench/tb_msm_fetch.sv
// MSM fetch front end testbench

`timescale 1ns/100ps

module tb_msm_fetch;

  logic                                                          ap_clk;
  logic                                                          areset;
  logic                                                          ap_start;
  logic                                                          ap_idle;
  logic                                                          ap_done;
  logic                                                          ap_ready;
  msm_fetch_pkg::count_t                                         num_points;
  msm_fetch_pkg::addr_t                                          scalar_base;
  msm_fetch_pkg::addr_t                                          point_x_base;
  msm_fetch_pkg::addr_t                                          point_y_base;
  logic [msm_fetch_pkg::NUM_CHANNELS-1:0]                        ar_valid;
  logic [msm_fetch_pkg::NUM_CHANNELS-1:0]                        ar_ready;
  msm_fetch_pkg::addr_t [msm_fetch_pkg::NUM_CHANNELS-1:0]        ar_addr;
  logic [msm_fetch_pkg::NUM_CHANNELS-1:0][msm_fetch_pkg::LEN_W-1:0] ar_len;
  logic [msm_fetch_pkg::NUM_CHANNELS-1:0]                        r_valid;
  logic [msm_fetch_pkg::NUM_CHANNELS-1:0]                        r_ready;
  msm_fetch_pkg::elem_t [msm_fetch_pkg::NUM_CHANNELS-1:0]        r_data;
  logic [msm_fetch_pkg::NUM_CHANNELS-1:0]                        r_last;
  logic                                                          tuple_valid;
  logic                                                          tuple_ready;
  msm_fetch_pkg::tuple_t                                         tuple_data;

  // Memory model and monitor state
  integer                seed = 32'h9868;
  bit                    gaps;
  bit                    stall;
  bit                    ar_seen;
  int                    cycle;
  msm_fetch_pkg::addr_t  burst_addr [msm_fetch_pkg::NUM_CHANNELS][16];
  int                    burst_len [msm_fetch_pkg::NUM_CHANNELS][16];
  int                    ar_cnt [msm_fetch_pkg::NUM_CHANNELS];
  int                    b_rd [msm_fetch_pkg::NUM_CHANNELS];
  int                    beat [msm_fetch_pkg::NUM_CHANNELS];
  bit                    r_hold [msm_fetch_pkg::NUM_CHANNELS];
  msm_fetch_pkg::tuple_t got_q [$];
  int                    last_hs_cycle;
  int                    done_count;
  int                    ready_count;
  int                    done_cycle;
  logic                  ready_at_done;
  logic                  idle_at_done;
  logic                  idle_before_done;
  logic                  idle_prev;
  int                    errors;
  int                    checks;
  int                    tests;

  msm_fetch_top UUT (.*);

  initial begin
    ap_clk = 1'b0;
    forever #10 ap_clk = ~ap_clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Reference rules
  ////////////////////////////////////////////////////////////////////////////

  // Channel index in the top byte, byte address in the low word
  function automatic msm_fetch_pkg::elem_t tagged_elem(input int ch,
                                                       input msm_fetch_pkg::addr_t addr);
    return {8'(ch), 24'h0, addr};
  endfunction

  function automatic msm_fetch_pkg::addr_t region_base(input int ch);
    case (ch)
      msm_fetch_pkg::CH_SCALAR:  return scalar_base;
      msm_fetch_pkg::CH_POINT_X: return point_x_base;
      default:                   return point_y_base;
    endcase
  endfunction

  function automatic msm_fetch_pkg::tuple_t expected_tuple(input int i);
    msm_fetch_pkg::tuple_t t;
    msm_fetch_pkg::addr_t  offs;
    offs     = msm_fetch_pkg::addr_t'(i * msm_fetch_pkg::BYTES_PER_BEAT);
    t.scalar = tagged_elem(msm_fetch_pkg::CH_SCALAR, scalar_base + offs);
    t.x      = tagged_elem(msm_fetch_pkg::CH_POINT_X, point_x_base + offs);
    t.y      = tagged_elem(msm_fetch_pkg::CH_POINT_Y, point_y_base + offs);
    return t;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory responder, tuple sink and monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge ap_clk) begin
    msm_fetch_pkg::addr_t addr;
    cycle = cycle + 1;
    for (int ch = 0; ch < msm_fetch_pkg::NUM_CHANNELS; ch++) begin
      r_hold[ch] = r_valid[ch] && !r_ready[ch];
      if (ar_valid[ch]) begin
        ar_seen = 1'b1;
      end
      if (ar_valid[ch] && ar_ready[ch] && ar_cnt[ch] < 16) begin
        burst_addr[ch][ar_cnt[ch]] = ar_addr[ch];
        burst_len[ch][ar_cnt[ch]]  = int'(ar_len[ch]);
        ar_cnt[ch]++;
      end
      if (r_valid[ch] && r_ready[ch]) begin
        if (beat[ch] == burst_len[ch][b_rd[ch]]) begin
          beat[ch] = 0;
          b_rd[ch]++;
        end else begin
          beat[ch]++;
        end
      end
    end
    if (tuple_valid && tuple_ready) begin
      got_q.push_back(tuple_data);
      last_hs_cycle = cycle;
    end
    if (ap_ready) begin
      ready_count++;
    end
    if (ap_done) begin
      done_count++;
      done_cycle       = cycle;
      ready_at_done    = ap_ready;
      idle_at_done     = ap_idle;
      idle_before_done = idle_prev;
    end
    idle_prev = ap_idle;
    #2;
    for (int ch = 0; ch < msm_fetch_pkg::NUM_CHANNELS; ch++) begin
      ar_ready[ch] = gaps ? (($random(seed) & 3) != 0) : 1'b1;
      if (b_rd[ch] != ar_cnt[ch]) begin
        // A beat already offered stays valid until taken
        if (!r_hold[ch]) begin
          r_valid[ch] = gaps ? (($random(seed) & 3) != 0) : 1'b1;
        end
        addr = burst_addr[ch][b_rd[ch]] +
               msm_fetch_pkg::addr_t'(beat[ch] * msm_fetch_pkg::BYTES_PER_BEAT);
        r_data[ch] = tagged_elem(ch, addr);
        r_last[ch] = (beat[ch] == burst_len[ch][b_rd[ch]]);
      end else begin
        r_valid[ch] = 1'b0;
        r_last[ch]  = 1'b0;
      end
    end
    tuple_ready = stall ? (($random(seed) & 1) != 0) : 1'b1;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_tuple(input string name, input msm_fetch_pkg::tuple_t exp,
                             input msm_fetch_pkg::tuple_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_addr(input string name, input msm_fetch_pkg::addr_t exp,
                            input msm_fetch_pkg::addr_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("FAILED %0t %s expected %0d actual %0d", $time, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Run helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic start_run(input int n, output int start_cycle);
    @(posedge ap_clk);
    #2;
    got_q.delete();
    done_count    = 0;
    ready_count   = 0;
    last_hs_cycle = 0;
    ar_seen       = 1'b0;
    for (int ch = 0; ch < msm_fetch_pkg::NUM_CHANNELS; ch++) begin
      ar_cnt[ch] = 0;
      b_rd[ch]   = 0;
      beat[ch]   = 0;
    end
    num_points  = msm_fetch_pkg::count_t'(n);
    ap_start    = 1'b1;
    start_cycle = cycle;
    @(posedge ap_clk);
    #2;
    ap_start = 1'b0;
  endtask

  task automatic wait_done(input int limit);
    int n;
    n = 0;
    while (done_count == 0 && n < limit) begin
      @(posedge ap_clk);
      #2;
      n++;
    end
    if (done_count == 0) begin
      errors++;
      $display("Timeout: no ap_done within %0d cycles", limit);
    end
    // Watch for a second done pulse or stray tuples
    repeat (4) begin
      @(posedge ap_clk);
      #2;
    end
  endtask

  task automatic check_run(input int n);
    check_count("tuple count", n, got_q.size());
    for (int i = 0; i < n && i < got_q.size(); i++) begin
      check_tuple($sformatf("tuple_data[%0d]", i), expected_tuple(i), got_q[i]);
    end
    check_count("ap_done pulses", 1, done_count);
    check_count("ap_ready pulses", 1, ready_count);
    check_count("ap_done cycle", last_hs_cycle + 1, done_cycle);
    check_flag("ap_ready", 1'b1, ready_at_done);
    check_flag("ap_idle with ap_done", 1'b1, idle_at_done);
    check_flag("ap_idle before ap_done", 1'b0, idle_before_done);
  endtask

  task automatic report_test(input string name, input int err0);
    tests++;
    $display("%s: finished, %0d errors", name, errors - err0);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic reset_state();
    int err0;
    err0 = errors;
    check_flag("ap_idle", 1'b1, ap_idle);
    check_flag("ap_done", 1'b0, ap_done);
    check_flag("ap_ready", 1'b0, ap_ready);
    check_flag("tuple_valid", 1'b0, tuple_valid);
    for (int ch = 0; ch < msm_fetch_pkg::NUM_CHANNELS; ch++) begin
      check_flag($sformatf("ar_valid[%0d]", ch), 1'b0, ar_valid[ch]);
    end
    report_test("reset state", err0);
  endtask

  task automatic single_burst_run();
    int err0;
    int sc;
    err0 = errors;
    start_run(5, sc);
    wait_done(200);
    check_run(5);
    report_test("single burst run", err0);
  endtask

  task automatic multi_burst_addressing();
    int err0;
    int sc;
    int exp_len [3] = '{7, 7, 4};
    err0 = errors;
    start_run(21, sc);
    wait_done(400);
    check_run(21);
    for (int ch = 0; ch < msm_fetch_pkg::NUM_CHANNELS; ch++) begin
      check_count($sformatf("burst count ch%0d", ch), 3, ar_cnt[ch]);
      for (int k = 0; k < 3 && k < ar_cnt[ch]; k++) begin
        check_addr($sformatf("ar_addr[%0d] burst %0d", ch, k),
                   region_base(ch) + msm_fetch_pkg::addr_t'(64 * k), burst_addr[ch][k]);
        check_count($sformatf("ar_len[%0d] burst %0d", ch, k), exp_len[k], burst_len[ch][k]);
      end
    end
    report_test("multi burst addressing", err0);
  endtask

  task automatic back_pressure();
    int err0;
    int sc;
    err0  = errors;
    gaps  = 1'b1;
    stall = 1'b1;
    start_run(40, sc);
    wait_done(3000);
    gaps  = 1'b0;
    stall = 1'b0;
    check_run(40);
    report_test("back-pressure", err0);
  endtask

  task automatic zero_points_restart();
    int err0;
    int sc;
    err0 = errors;
    start_run(0, sc);
    wait_done(50);
    check_count("ap_done pulses", 1, done_count);
    check_count("ap_ready pulses", 1, ready_count);
    // Edge seen one cycle after the drive, done two later, sampled one after
    check_count("ap_done cycle", sc + 4, done_cycle);
    check_flag("ar_valid seen", 1'b0, ar_seen);
    check_count("tuple count", 0, got_q.size());
    start_run(5, sc);
    wait_done(200);
    check_run(5);
    report_test("zero points and restart", err0);
  endtask

  initial begin : main
    int sva_fails;
    areset       = 1'b1;
    ap_start     = 1'b0;
    num_points   = '0;
    scalar_base  = 32'h0001_0000;
    point_x_base = 32'h0002_0040;
    point_y_base = 32'h0003_0080;
    ar_ready     = '0;
    r_valid      = '0;
    r_data       = '0;
    r_last       = '0;
    tuple_ready  = 1'b1;
    idle_prev    = 1'b1;
    repeat (5) @(posedge ap_clk);
    #2;
    areset = 1'b0;

    reset_state();
    single_burst_run();
    multi_burst_addressing();
    back_pressure();
    zero_points_restart();

    sva_fails = UUT.g_reader[0].u_burst_reader.u_sva.fail_count +
                UUT.g_reader[1].u_burst_reader.u_sva.fail_count +
                UUT.g_reader[2].u_burst_reader.u_sva.fail_count;
    if (sva_fails != 0) begin
      errors += sva_fails;
      $display("%0d assertion failures in the burst readers", sva_fails);
    end
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- bench/msm_fetch_sva.sv
// Burst reader protocol checks

`timescale 1ns/100ps

module msm_fetch_sva (
  input logic                            ap_clk,
  input logic                            areset,
  input logic                            ar_valid,
  input logic                            ar_ready,
  input msm_fetch_pkg::addr_t            ar_addr,
  input logic [msm_fetch_pkg::LEN_W-1:0] ar_len,
  input logic                            r_valid,
  input logic                            r_ready,
  input msm_fetch_pkg::count_t           outstanding
);

  // Failures seen by this instance
  int fail_count = 0;

  // AR request holds its payload until accepted
  ar_hold: assert property (@(posedge ap_clk) disable iff (areset)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
    else begin
      fail_count++;
      $error("AR request changed or dropped before ar_ready");
    end

  // Credit keeps a free FIFO slot for every requested beat
  credit_room: assert property (@(posedge ap_clk) disable iff (areset)
    r_valid && (outstanding != '0) |-> r_ready)
    else begin
      fail_count++;
      $error("Requested beat met a full read FIFO");
    end

endmodule

bind burst_reader msm_fetch_sva u_sva (
  .ap_clk      (ap_clk),
  .areset      (areset),
  .ar_valid    (ar_valid),
  .ar_ready    (ar_ready),
  .ar_addr     (ar_addr),
  .ar_len      (ar_len),
  .r_valid     (r_valid),
  .r_ready     (r_ready),
  .outstanding (outstanding)
);

//--- hw/msm_fetch_top.sv
// MSM memory fetch front end, top level

`timescale 1ns/100ps

module msm_fetch_top (
  input  wire                                                    ap_clk,
  input  wire                                                    areset,
  // Kernel control
  input  wire                                                    ap_start,
  output wire                                                    ap_idle,
  output wire                                                    ap_done,
  output wire                                                    ap_ready,
  input  msm_fetch_pkg::count_t                                  num_points,
  input  msm_fetch_pkg::addr_t                                   scalar_base,
  input  msm_fetch_pkg::addr_t                                   point_x_base,
  input  msm_fetch_pkg::addr_t                                   point_y_base,
  // Read address, one lane per region
  output wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  ar_valid,
  input  wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  ar_ready,
  output msm_fetch_pkg::addr_t [msm_fetch_pkg::NUM_CHANNELS-1:0] ar_addr,
  output wire [msm_fetch_pkg::NUM_CHANNELS-1:0][msm_fetch_pkg::LEN_W-1:0] ar_len,
  // Read data
  input  wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  r_valid,
  output wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  r_ready,
  input  msm_fetch_pkg::elem_t [msm_fetch_pkg::NUM_CHANNELS-1:0] r_data,
  input  wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  r_last,
  // Tuple stream
  output wire                                                    tuple_valid,
  input  wire                                                    tuple_ready,
  output msm_fetch_pkg::tuple_t                                  tuple_data
);

  wire                                                    run_start;
  wire                                                    run_finished;
  msm_fetch_pkg::addr_t [msm_fetch_pkg::NUM_CHANNELS-1:0] base_addr;
  wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  elem_valid;
  wire [msm_fetch_pkg::NUM_CHANNELS-1:0]                  elem_ready;
  msm_fetch_pkg::elem_t [msm_fetch_pkg::NUM_CHANNELS-1:0] elem_data;

  assign base_addr[msm_fetch_pkg::CH_SCALAR]  = scalar_base;
  assign base_addr[msm_fetch_pkg::CH_POINT_X] = point_x_base;
  assign base_addr[msm_fetch_pkg::CH_POINT_Y] = point_y_base;

  kernel_ctrl u_kernel_ctrl (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .ap_start     (ap_start),
    .run_finished (run_finished),
    .run_start    (run_start),
    .ap_idle      (ap_idle),
    .ap_done      (ap_done),
    .ap_ready     (ap_ready)
  );

  ////////////////////////////////////////////////////////////////////////////
  // One reader per memory region
  ////////////////////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < msm_fetch_pkg::NUM_CHANNELS; ch++) begin : g_reader
    burst_reader u_burst_reader (
      .ap_clk     (ap_clk),
      .areset     (areset),
      .run_start  (run_start),
      .base_addr  (base_addr[ch]),
      .num_points (num_points),
      .ar_valid   (ar_valid[ch]),
      .ar_addr    (ar_addr[ch]),
      .ar_len     (ar_len[ch]),
      .ar_ready   (ar_ready[ch]),
      .r_valid    (r_valid[ch]),
      .r_data     (r_data[ch]),
      .r_last     (r_last[ch]),
      .r_ready    (r_ready[ch]),
      .elem_valid (elem_valid[ch]),
      .elem_ready (elem_ready[ch]),
      .elem_data  (elem_data[ch])
    );
  end

  tuple_joiner u_tuple_joiner (
    .ap_clk       (ap_clk),
    .areset       (areset),
    .run_start    (run_start),
    .num_points   (num_points),
    .elem_valid   (elem_valid),
    .elem_data    (elem_data),
    .elem_ready   (elem_ready),
    .tuple_valid  (tuple_valid),
    .tuple_ready  (tuple_ready),
    .tuple_data   (tuple_data),
    .run_finished (run_finished)
  );

endmodule

//--- hw/fetch/tuple_joiner.sv
// Joins scalar, x and y streams into tuples

`timescale 1ns/100ps

module tuple_joiner (
  input  logic                                               ap_clk,
  input  logic                                               areset,
  input  logic                                               run_start,
  input  msm_fetch_pkg::count_t                              num_points,
  input  logic [msm_fetch_pkg::NUM_CHANNELS-1:0]             elem_valid,
  input  msm_fetch_pkg::elem_t [msm_fetch_pkg::NUM_CHANNELS-1:0] elem_data,
  output logic [msm_fetch_pkg::NUM_CHANNELS-1:0]             elem_ready,
  output logic                                               tuple_valid,
  input  logic                                               tuple_ready,
  output msm_fetch_pkg::tuple_t                              tuple_data,
  output logic                                               run_finished
);

  msm_fetch_pkg::tuple_t  stage_data;
  logic                   stage_valid;
  logic                   join_fire;
  logic                   out_fire;
  logic                   running;
  msm_fetch_pkg::count_t  num_q;
  msm_fetch_pkg::count_t  tuples_out;
  msm_fetch_pkg::count_t  tuples_next;
  logic [$clog2(msm_fetch_pkg::TUPLE_FIFO_DEPTH+1)-1:0] tuple_free;

  // A slot is reserved for the staged tuple as well as the new one
  assign join_fire  = (&elem_valid) && (stage_valid ? (tuple_free > 1) : (tuple_free != 0));
  assign elem_ready = {msm_fetch_pkg::NUM_CHANNELS{join_fire}};

  // Stage register, so a join reaches the FIFO a cycle later
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= join_fire;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (join_fire) begin
      stage_data.scalar <= elem_data[msm_fetch_pkg::CH_SCALAR];
      stage_data.x      <= elem_data[msm_fetch_pkg::CH_POINT_X];
      stage_data.y      <= elem_data[msm_fetch_pkg::CH_POINT_Y];
    end
  end

  // in_ready left open, the slot was checked at join time
  stream_fifo #(
    .data_t (msm_fetch_pkg::tuple_t),
    .DEPTH  (msm_fetch_pkg::TUPLE_FIFO_DEPTH)
  ) u_tuple_fifo (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .in_valid   (stage_valid),
    .in_ready   (),
    .in_data    (stage_data),
    .out_valid  (tuple_valid),
    .out_ready  (tuple_ready),
    .out_data   (tuple_data),
    .free_slots (tuple_free)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Run accounting
  ////////////////////////////////////////////////////////////////////////////

  assign out_fire    = tuple_valid & tuple_ready;
  assign tuples_next = tuples_out + msm_fetch_pkg::count_t'(out_fire);

  // Finishes in the cycle of the last handshake, or at once for zero points
  assign run_finished = running && (tuples_next == num_q);

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      running    <= 1'b0;
      num_q      <= '0;
      tuples_out <= '0;
    end else if (run_start) begin
      running    <= 1'b1;
      num_q      <= num_points;
      tuples_out <= '0;
    end else begin
      tuples_out <= tuples_next;
      if (run_finished) begin
        running <= 1'b0;
      end
    end
  end

endmodule

//--- hw/fetch/burst_reader.sv
// Burst read master for one memory region

`timescale 1ns/100ps

module burst_reader (
  input  logic                              ap_clk,
  input  logic                              areset,
  input  logic                              run_start,
  input  msm_fetch_pkg::addr_t              base_addr,
  input  msm_fetch_pkg::count_t             num_points,
  // AR channel
  output logic                              ar_valid,
  output msm_fetch_pkg::addr_t              ar_addr,
  output logic [msm_fetch_pkg::LEN_W-1:0]   ar_len,
  input  logic                              ar_ready,
  // R channel
  input  logic                              r_valid,
  input  msm_fetch_pkg::elem_t              r_data,
  input  logic                              r_last,
  output logic                              r_ready,
  // Element stream
  output logic                              elem_valid,
  input  logic                              elem_ready,
  output msm_fetch_pkg::elem_t              elem_data
);

  msm_fetch_pkg::addr_t   next_addr;
  msm_fetch_pkg::count_t  remaining;
  msm_fetch_pkg::count_t  outstanding;
  msm_fetch_pkg::count_t  bursts_open;
  msm_fetch_pkg::count_t  burst_beats;
  msm_fetch_pkg::count_t  credit;
  logic [$clog2(msm_fetch_pkg::READ_FIFO_DEPTH+1)-1:0] fifo_free;
  logic                   issue;
  logic                   ar_done;
  logic                   r_accept;
  logic                   push;

  ////////////////////////////////////////////////////////////////////////////
  // Burst sizing and credit
  ////////////////////////////////////////////////////////////////////////////

  // Full bursts, then whatever is left
  assign burst_beats =
    (remaining > msm_fetch_pkg::count_t'(msm_fetch_pkg::MAX_BURST_BEATS)) ?
    msm_fetch_pkg::count_t'(msm_fetch_pkg::MAX_BURST_BEATS) : remaining;

  // Slots not yet claimed by requested beats
  assign credit = msm_fetch_pkg::count_t'(fifo_free) - outstanding;

  assign issue    = !ar_valid && (remaining != '0) && (credit >= burst_beats);
  assign ar_done  = ar_valid & ar_ready;
  assign r_accept = r_valid & r_ready;

  // Beats outside any open burst are dropped
  assign push = r_accept && (bursts_open != '0);

  ////////////////////////////////////////////////////////////////////////////
  // Request side
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ar_valid  <= 1'b0;
      next_addr <= '0;
      remaining <= '0;
    end else if (run_start) begin
      next_addr <= base_addr;
      remaining <= num_points;
    end else begin
      if (issue) begin
        ar_valid  <= 1'b1;
        next_addr <= next_addr + msm_fetch_pkg::addr_t'(burst_beats) *
                     msm_fetch_pkg::addr_t'(msm_fetch_pkg::BYTES_PER_BEAT);
        remaining <= remaining - burst_beats;
      end else if (ar_done) begin
        ar_valid <= 1'b0;
      end
    end
  end

  // AR payload is held until the handshake
  always_ff @(posedge ap_clk) begin
    if (issue) begin
      ar_addr <= next_addr;
      ar_len  <= burst_beats[msm_fetch_pkg::LEN_W-1:0] - 1'b1;
    end
  end

  // Beats claimed at issue, released as each one lands in the FIFO
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      outstanding <= '0;
      bursts_open <= '0;
    end else begin
      outstanding <= outstanding + (issue ? burst_beats : '0) -
                     msm_fetch_pkg::count_t'(push);
      bursts_open <= bursts_open + msm_fetch_pkg::count_t'(ar_done) -
                     msm_fetch_pkg::count_t'(push && r_last);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Data side
  ////////////////////////////////////////////////////////////////////////////

  stream_fifo #(
    .data_t (msm_fetch_pkg::elem_t),
    .DEPTH  (msm_fetch_pkg::READ_FIFO_DEPTH)
  ) u_read_fifo (
    .ap_clk     (ap_clk),
    .areset     (areset),
    .in_valid   (push),
    .in_ready   (r_ready),
    .in_data    (r_data),
    .out_valid  (elem_valid),
    .out_ready  (elem_ready),
    .out_data   (elem_data),
    .free_slots (fifo_free)
  );

endmodule

//--- hw/kernel_ctrl.sv
// Kernel start and done control

`timescale 1ns/100ps

module kernel_ctrl (
  input  logic ap_clk,
  input  logic areset,
  input  logic ap_start,
  input  logic run_finished,
  output logic run_start,
  output logic ap_idle,
  output logic ap_done,
  output logic ap_ready
);

  logic ap_start_r;
  logic start_edge;

  // Previous ap_start, for edge detection
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_start_r <= 1'b0;
    end else begin
      ap_start_r <= ap_start;
    end
  end

  // A new edge while a run is busy is ignored
  assign start_edge = ap_start & ~ap_start_r & ap_idle;

  always_ff @(posedge ap_clk) begin
    if (areset) begin
      run_start <= 1'b0;
    end else begin
      run_start <= start_edge;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Idle and done
  ////////////////////////////////////////////////////////////////////////////

  // Idle falls on the start edge and rises together with done
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_idle <= 1'b1;
    end else if (run_finished) begin
      ap_idle <= 1'b1;
    end else if (start_edge) begin
      ap_idle <= 1'b0;
    end
  end

  // One-cycle done pulse
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      ap_done <= 1'b0;
    end else begin
      ap_done <= run_finished;
    end
  end

  // Not pipelined, so ready follows done
  assign ap_ready = ap_done;

endmodule

//--- hw/stream_fifo.sv
// Valid/ready FIFO with generic payload

`timescale 1ns/100ps

module stream_fifo #(
  parameter type data_t = logic [63:0],
  parameter int  DEPTH  = 16
) (
  input  logic                         ap_clk,
  input  logic                         areset,
  input  logic                         in_valid,
  output logic                         in_ready,
  input  data_t                        in_data,
  output logic                         out_valid,
  input  logic                         out_ready,
  output data_t                        out_data,
  output logic [$clog2(DEPTH+1)-1:0]   free_slots
);

  data_t                        mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr;
  logic [$clog2(DEPTH)-1:0]     rd_ptr;
  logic [$clog2(DEPTH+1)-1:0]   fill;
  logic                         push;
  logic                         pop;

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // Storage
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap explicitly so DEPTH need not be a power of two
  always_ff @(posedge ap_clk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ($clog2(DEPTH))'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        fill <= fill + 1'b1;
      end else if (pop && !push) begin
        fill <= fill - 1'b1;
      end
    end
  end

  assign in_ready   = (fill != ($clog2(DEPTH+1))'(DEPTH));
  assign out_valid  = (fill != '0);
  assign out_data   = mem[rd_ptr];
  assign free_slots = ($clog2(DEPTH+1))'(DEPTH) - fill;

endmodule

//--- common/msm_fetch_pkg.sv
// MSM fetch front end
// Shared widths, burst constants and payload types

package msm_fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Channels
  ////////////////////////////////////////////////////////////////////////////

  // Scalars, point x and point y regions
  localparam int NUM_CHANNELS = 3;
  localparam int CH_SCALAR    = 0;
  localparam int CH_POINT_X   = 1;
  localparam int CH_POINT_Y   = 2;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and burst shape
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADDR_W         = 32;
  localparam int ELEM_W         = 64;
  localparam int BYTES_PER_BEAT = 8;
  localparam int COUNT_W        = 16;

  // Full bursts are 64 bytes
  localparam int MAX_BURST_BEATS = 8;
  localparam int LEN_W           = 8;

  // Reader FIFO holds two full bursts
  localparam int READ_FIFO_DEPTH  = 16;
  localparam int TUPLE_FIFO_DEPTH = 4;

  ////////////////////////////////////////////////////////////////////////////
  // Payload types
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [ADDR_W-1:0]  addr_t;
  typedef logic [ELEM_W-1:0]  elem_t;
  typedef logic [COUNT_W-1:0] count_t;

  // One MSM input term, 192 bits
  typedef struct packed {
    elem_t scalar;
    elem_t x;
    elem_t y;
  } tuple_t;

endpackage
